// File: common/router_config.svh
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// Input ports L, N, E, W, S
`define ROUTER_PORTS 5

// Full flit word
`define FLIT_W 16

// Flit type field at the top of every word
`define FLIT_ID_W 3

// Packet length, also the hold counter width
`define LEN_W 12

`endif

// File: common/routerPkg.sv
`include "router_config.svh"

package routerPkg;

  // Flit type, only HEAD carries a length
  typedef enum logic [`FLIT_ID_W-1:0]
  {
    HEAD = 3'b001,
    BODY = 3'b010,
    TAIL = 3'b100
  } flitId_t;

  typedef struct packed
  {
    flitId_t                                  flitId;
    logic [`LEN_W-1:0]                        length;
    logic [`FLIT_W-`FLIT_ID_W-`LEN_W-1:0]     spare;
  } headerFlit_t;

  typedef struct packed
  {
    flitId_t                                  flitId;
    logic [`FLIT_W-`FLIT_ID_W-1:0]            data;
  } bodyFlit_t;

  // Same word, read as header or as body
  typedef union packed
  {
    headerFlit_t header;
    bodyFlit_t   body;
  } flitWord_t;

  // One input port
  typedef struct packed
  {
    logic      req;
    logic      valid;
    flitWord_t flit;
  } inPort_t;

  // One-hot, port bits above the idle bit
  typedef enum logic [`ROUTER_PORTS:0]
  {
    ST_IDLE = 6'b000001,
    ST_L    = 6'b000010,
    ST_N    = 6'b000100,
    ST_E    = 6'b001000,
    ST_W    = 6'b010000,
    ST_S    = 6'b100000
  } arbState_t;

endpackage

// File: arbiter/holdTimer.sv
`timescale 1ns/100ps
`include "router_config.svh"

module holdTimer
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  inPort_t inPort,
  input  logic    runTimer,
  output logic    timesUp
);

  logic [`LEN_W-1:0] limit;
  logic [`LEN_W-1:0] count;
  headerFlit_t       header;

  assign header = inPort.flit.header; // Header view of the word

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (inPort.valid && (header.flitId == HEAD))
      begin
        limit <= header.length; // Latest header sets the limit
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0; // Restart on every new grant
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

// File: arbiter/portArbiter.sv
`timescale 1ns/100ps
`include "router_config.svh"

module portArbiter
  import routerPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  inPort_t                  inPorts [`ROUTER_PORTS],
  output logic [`ROUTER_PORTS-1:0] grant
);

  arbState_t                state;
  arbState_t                nextState;
  logic [`ROUTER_PORTS-1:0] reqs;
  logic [`ROUTER_PORTS-1:0] runTimer;
  logic [`ROUTER_PORTS-1:0] timesUp;
  int                       curPort;

  // First requester among span ports, starting at index start and wrapping
  function automatic arbState_t pickFrom
  (
    input logic [`ROUTER_PORTS-1:0] req,
    input int                       start,
    input int                       span
  );
    arbState_t             pick;
    logic [`ROUTER_PORTS:0] oneHot;
    logic                  found;
    int                    idx;
    pick  = ST_IDLE;
    found = 1'b0;
    for (int k = 0; k < `ROUTER_PORTS; k++)
    begin
      idx = start + k;
      if (idx >= `ROUTER_PORTS)
      begin
        idx = idx - `ROUTER_PORTS;
      end
      if ((k < span) && !found && req[idx])
      begin
        found       = 1'b1;
        oneHot      = '0;
        oneHot[idx+1] = 1'b1;
        pick        = arbState_t'(oneHot);
      end
    end
    return pick;
  endfunction

  always_comb
  begin
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      reqs[i] = inPorts[i].req;
    end
  end

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : genTimer
    holdTimer holdTimer_inst
    (
      .clk      (clk),
      .rst      (rst),
      .inPort   (inPorts[i]),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  // Port index of the current holder
  always_comb
  begin
    case (state)
      ST_L:    curPort = 0;
      ST_N:    curPort = 1;
      ST_E:    curPort = 2;
      ST_W:    curPort = 3;
      ST_S:    curPort = 4;
      default: curPort = 0;
    endcase
  end

  always_comb
  begin
    nextState = ST_IDLE;
    runTimer  = '0;
    case (state)
      ST_IDLE:
      begin
        nextState = pickFrom(reqs, 0, `ROUTER_PORTS); // Fixed order L first
      end
      ST_L, ST_N, ST_E, ST_W, ST_S:
      begin
        if (reqs[curPort] && !timesUp[curPort])
        begin
          nextState         = state; // Keep holding
          runTimer[curPort] = 1'b1;
        end
        else
        begin
          // Rotate past the holder, which is left out
          nextState = pickFrom(reqs, curPort + 1, `ROUTER_PORTS - 1);
        end
      end
      default:
      begin
        nextState = ST_IDLE;
      end
    endcase
  end

  assign grant = state[`ROUTER_PORTS:1];

endmodule

// File: source/flitCrossbar.sv
`timescale 1ns/100ps
`include "router_config.svh"

module flitCrossbar
  import routerPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  inPort_t                  inPorts [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0] grant,
  output flitWord_t                outFlit,
  output logic                     outValid
);

  logic [`FLIT_W-1:0] selFlit;
  logic               selValid;

  // Grant is one-hot or zero, so an OR of masked inputs selects
  always_comb
  begin
    selFlit  = '0;
    selValid = 1'b0;
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      if (grant[i])
      begin
        selFlit  = selFlit | inPorts[i].flit;
        selValid = selValid | inPorts[i].valid;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit  <= flitWord_t'(selFlit);
      outValid <= selValid; // Low on a zero grant
    end
  end

endmodule

// File: source/routerOutputPort.sv
`timescale 1ns/100ps
`include "router_config.svh"

module routerOutputPort
  import routerPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  inPort_t                  inPorts [`ROUTER_PORTS],
  output logic [`ROUTER_PORTS-1:0] grant,
  output flitWord_t                outFlit,
  output logic                     outValid
);

  // Arbiter output also steers the crossbar
  portArbiter portArbiter_inst
  (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant)
  );

  flitCrossbar flitCrossbar_inst
  (
    .clk      (clk),
    .rst      (rst),
    .inPorts  (inPorts),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// File: tests/arbiterModel.svh
`ifndef ARBITER_MODEL_SVH
`define ARBITER_MODEL_SVH

// Reference model of the output port, stepped once per edge on the inputs held in stim

int                mHolder;   // Port holding the grant, -1 when idle
logic [`LEN_W-1:0] mLimit [`ROUTER_PORTS];
logic [`LEN_W-1:0] mCount [`ROUTER_PORTS];
flitWord_t         mOutFlit;
logic              mOutValid;
logic              mOutKnown; // A port was granted on the last edge

task automatic modelReset();
  mHolder   = -1;
  mOutFlit  = '0;
  mOutValid = 1'b0;
  mOutKnown = 1'b0;
  for (int i = 0; i < `ROUTER_PORTS; i++)
  begin
    mLimit[i] = '0;
    mCount[i] = '0;
  end
endtask

function automatic logic [`ROUTER_PORTS-1:0] modelGrant();
  logic [`ROUTER_PORTS-1:0] g;
  for (int i = 0; i < `ROUTER_PORTS; i++)
  begin
    g[i] = (mHolder == i);
  end
  return g;
endfunction

task automatic modelStep();
  int          nextHolder;
  int          idx;
  headerFlit_t hdr;
  nextHolder = -1;
  if (mHolder < 0)
  begin
    for (int k = 0; k < `ROUTER_PORTS; k++)
    begin
      if ((nextHolder < 0) && stim[k].req)
      begin
        nextHolder = k; // Fixed order from idle
      end
    end
  end
  else if (stim[mHolder].req && (mCount[mHolder] != mLimit[mHolder]))
  begin
    nextHolder = mHolder;
  end
  else
  begin
    for (int k = 1; k < `ROUTER_PORTS; k++)
    begin
      idx = (mHolder + k) % `ROUTER_PORTS;
      if ((nextHolder < 0) && stim[idx].req)
      begin
        nextHolder = idx;
      end
    end
  end
  mOutKnown = (mHolder >= 0);
  mOutValid = 1'b0;
  for (int i = 0; i < `ROUTER_PORTS; i++)
  begin
    if (i == mHolder)
    begin
      mOutFlit  = stim[i].flit;
      mOutValid = stim[i].valid;
    end
    hdr = stim[i].flit.header;
    if (stim[i].valid && (hdr.flitId == HEAD))
    begin
      mLimit[i] = hdr.length;
    end
    if ((i == mHolder) && (nextHolder == mHolder))
    begin
      mCount[i] = mCount[i] + 1'b1;
    end
    else
    begin
      mCount[i] = '0;
    end
  end
  mHolder = nextHolder;
endtask

`endif

// File: tests/routerOutputPortTb.sv
`timescale 1ns/100ps
`include "router_config.svh"

module routerOutputPortTb
  import routerPkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 8;
  localparam int DIRECTED_CYCLES = 80;
  localparam int SOAK_CYCLES     = 4000;
  localparam int MARGIN_CYCLES   = 200;
  localparam int WATCH_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + SOAK_CYCLES + MARGIN_CYCLES;
  localparam int HOLD_LEN        = 4;

  logic                     clk;
  logic                     rst;
  inPort_t                  inPorts [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0] grant;
  flitWord_t                outFlit;
  logic                     outValid;

  inPort_t                  stim [`ROUTER_PORTS]; // Inputs for the next edge
  integer                   seed;
  int                       held;

  `include "arbiterModel.svh"

  routerOutputPort routerOutputPort_inst
  (
    .clk      (clk),
    .rst      (rst),
    .inPorts  (inPorts),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic failValue(input string testName, input string sigName,
                           input logic [31:0] expected, input logic [31:0] actual);
    $display("[ERROR] %s: %s expected %0h, actual %0h", testName, sigName, expected, actual);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  function automatic flitWord_t makeHead(input logic [`LEN_W-1:0] len);
    flitWord_t w;
    w.header.flitId = HEAD;
    w.header.length = len;
    w.header.spare  = '0;
    return w;
  endfunction

  function automatic flitWord_t makeBody(input logic [`FLIT_W-`FLIT_ID_W-1:0] data);
    flitWord_t w;
    w.body.flitId = BODY;
    w.body.data   = data;
    return w;
  endfunction

  task automatic setReqs(input logic [`ROUTER_PORTS-1:0] reqs);
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      stim[i].req = reqs[i];
    end
  endtask

  task automatic clearValid();
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      stim[i].valid = 1'b0;
    end
  endtask

  task automatic expectGrant(input string testName, input logic [`ROUTER_PORTS-1:0] exp);
    assert (grant == exp)
      else failValue(testName, "grant", 32'(exp), 32'(grant));
  endtask

  // Drive stim, step the model on the edge, compare once outputs have settled
  task automatic tick(input string testName);
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      inPorts[i] = stim[i];
    end
    @(posedge clk);
    modelStep();
    #1;
    assert (grant == modelGrant())
      else failValue(testName, "grant", 32'(modelGrant()), 32'(grant));
    assert (outValid == mOutValid)
      else failValue(testName, "outValid", 32'(mOutValid), 32'(outValid));
    if (mOutKnown)
    begin
      assert (outFlit == mOutFlit)
        else failValue(testName, "outFlit", 32'(mOutFlit), 32'(outFlit));
    end
  endtask

  task automatic randomizePorts();
    logic [31:0] rnd;
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00)
      begin
        stim[i].req = !stim[i].req; // Requests persist and toggle now and then
      end
      stim[i].valid = rnd[2];
      if (rnd[3])
      begin
        stim[i].flit = makeHead(`LEN_W'(rnd[6:4]));
      end
      else
      begin
        stim[i].flit = makeBody(rnd[19:7]);
      end
    end
  endtask

  initial
  begin
    seed   = 32'hcbef9a38;
    held   = 0;
    rst    = 1'b1;
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      stim[i]          = '0;
      inPorts[i].req   = 1'b1; // Busy inputs while reset holds
      inPorts[i].valid = 1'b1;
      inPorts[i].flit  = makeHead(`LEN_W'(i + 1));
    end
    modelReset();
    repeat (RESET_CYCLES)
    begin
      @(posedge clk);
      #1;
      assert (grant == '0)
        else failValue("reset", "grant", 32'd0, 32'(grant));
      assert (outValid == 1'b0)
        else failValue("reset", "outValid", 32'd0, 32'(outValid));
    end
    rst = 1'b0;

    // Several requesters from idle
    setReqs(5'b11010);
    tick("idlePriority");
    expectGrant("idlePriority", 5'b00010);
    setReqs(5'b00000);
    tick("idlePriority");
    expectGrant("idlePriority", 5'b00000);
    setReqs(5'b11100);
    tick("idlePriority");
    expectGrant("idlePriority", 5'b00100);
    setReqs(5'b00000);
    tick("idlePriority");

    // Limits of 3 everywhere, then holders drop out one by one
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      stim[i].valid = 1'b1;
      stim[i].flit  = makeHead(`LEN_W'(3));
    end
    tick("rotation");
    clearValid();
    setReqs(5'b11111);
    tick("rotation");
    expectGrant("rotation", 5'b00001);
    setReqs(5'b11110);
    tick("rotation");
    expectGrant("rotation", 5'b00010);
    setReqs(5'b11100);
    tick("rotation");
    expectGrant("rotation", 5'b00100);
    setReqs(5'b11011);
    tick("rotation");
    expectGrant("rotation", 5'b01000);
    setReqs(5'b10011);
    tick("rotation");
    expectGrant("rotation", 5'b10000);
    setReqs(5'b00000);
    tick("rotation");
    expectGrant("rotation", 5'b00000);

    // West alone with a header of length HOLD_LEN
    stim[3].valid = 1'b1;
    stim[3].flit  = makeHead(`LEN_W'(HOLD_LEN));
    setReqs(5'b01000);
    tick("holdLimit");
    expectGrant("holdLimit", 5'b01000);
    clearValid();
    held = 1;
    tick("holdLimit");
    while ((grant == 5'b01000) && (held <= 4 * HOLD_LEN))
    begin
      held++;
      tick("holdLimit");
    end
    assert (held == HOLD_LEN + 1)
      else failValue("holdLimit", "held cycles", 32'(HOLD_LEN + 1), 32'(held));
    expectGrant("holdLimit", 5'b00000); // Idle for one cycle when alone
    tick("holdLimit");
    expectGrant("holdLimit", 5'b01000);
    setReqs(5'b00000);
    tick("holdLimit");

    // Forwarding is checked on every soak cycle against the model
    for (int c = 0; c < SOAK_CYCLES; c++)
    begin
      randomizePorts();
      tick("randomSoak");
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial
  begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCH_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: routerOutputPort.f
+incdir+common
+incdir+tests
common/routerPkg.sv
arbiter/holdTimer.sv
arbiter/portArbiter.sv
source/flitCrossbar.sv
source/routerOutputPort.sv
tests/routerOutputPortTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --assert --timing
TOP       = routerOutputPortTb
FILELIST  = routerOutputPort.f
OBJDIR    = obj_dir
PASSMSG   = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

# Static checks on the testbench and the whole design
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; the status comes from the search for the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
